/* logic/fifo_pkg.sv */
`default_nettype none

// Word formats seen on the host FIFOs and the data memory
package fifo_pkg;

	// Host FIFO word
	localparam int word_w = 32;

	// Coprocessor data memory word
	localparam int dword_w = 64;

	// All ones marks the end of a program
	localparam logic [word_w-1:0] prog_end = '1;

	// ==================================================
	// Data memory word
	// ==================================================

	// Read whole by the memory, read as two halves by the packer
	// Upper half goes out first
	typedef union packed {
		logic [dword_w-1:0] whole;
		struct packed {
			logic [word_w-1:0] hi;
			logic [word_w-1:0] lo;
		} halves;
	} data_word_t;

endpackage

`default_nettype wire

/* logic/loader_pkg.sv */
`default_nettype none

// Memory sizes and sequencer states
package loader_pkg;

	// Instruction memory, full size
	localparam int imem_words = 1024;
	localparam int imem_aw = 10;

	// Data memory, cut down for simulation
	localparam int dmem_words = 32;
	localparam int dmem_aw = 5;

	// Shared counter covers the larger memory
	localparam int cnt_w = 10;

	// ==================================================
	// Sequencer states
	// ==================================================

	typedef enum logic [3:0] {
		// Program load
		wait_word = 4'd0,
		read_gap  = 4'd1,
		take_word = 4'd2,
		next_load = 4'd3,
		// Coprocessor run
		start     = 4'd4,
		run       = 4'd5,
		stop      = 4'd6,
		// Result unload
		send_hi   = 4'd7,
		hi_gap    = 4'd8,
		send_lo   = 4'd9,
		lo_gap    = 4'd10,
		next_send = 4'd11
	} seq_state_t;

endpackage

`default_nettype wire

/* logic/load_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module load_sequencer (
	input  wire                          CLOCK_50,
	input  wire                          rst_n,
	input  wire                          in_empty,
	input  wire                          out_full,
	input  wire                          cpu_done,
	input  wire [fifo_pkg::word_w-1:0]   in_data,
	input  wire [loader_pkg::cnt_w-1:0]  count,
	output logic                         in_read,
	output logic                         imem_we,
	output logic                         cnt_clear,
	output logic                         cnt_step,
	output logic                         cpu_start,
	output logic                         cpu_run,
	output logic                         send_hi,
	output logic                         send_lo
);

	loader_pkg::seq_state_t state;
	logic last_word;

	// Counter sits on the final data memory entry
	assign last_word = (count == loader_pkg::cnt_w'(loader_pkg::dmem_words - 1));

	// ==================================================
	// Counter and packer strobes
	// ==================================================

	// Step after each stored instruction and each sent data word
	assign cnt_step = (state == loader_pkg::next_load) ||
		((state == loader_pkg::next_send) && !last_word);

	// Back to zero before unload and after the final word
	assign cnt_clear = (state == loader_pkg::start) ||
		((state == loader_pkg::next_send) && last_word);

	// Only fire a half when the outbound FIFO has room
	assign send_hi = (state == loader_pkg::send_hi) && !out_full;
	assign send_lo = (state == loader_pkg::send_lo) && !out_full;

	// ==================================================
	// State register and registered strobes
	// ==================================================

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= loader_pkg::wait_word;
			in_read <= 1'b0;
			imem_we <= 1'b0;
			cpu_start <= 1'b0;
			cpu_run <= 1'b0;
		end else begin
			// Single-cycle pulses by default
			in_read <= 1'b0;
			imem_we <= 1'b0;
			cpu_start <= 1'b0;
			unique case (state)
				// Pop once the host has queued a word
				loader_pkg::wait_word: begin
					if (!in_empty) begin
						in_read <= 1'b1;
						state <= loader_pkg::read_gap;
					end
				end
				// FIFO data settles here
				loader_pkg::read_gap: begin
					state <= loader_pkg::take_word;
				end
				// Terminator starts the run, anything else is stored
				loader_pkg::take_word: begin
					if (in_data == fifo_pkg::prog_end) begin
						cpu_start <= 1'b1;
						state <= loader_pkg::start;
					end else begin
						imem_we <= 1'b1;
						state <= loader_pkg::next_load;
					end
				end
				// Write lands at count, then count steps
				loader_pkg::next_load: begin
					state <= loader_pkg::wait_word;
				end
				// Start pulse is out, enable follows
				loader_pkg::start: begin
					cpu_run <= 1'b1;
					state <= loader_pkg::run;
				end
				loader_pkg::run: begin
					if (cpu_done) begin
						cpu_run <= 1'b0;
						state <= loader_pkg::stop;
					end
				end
				// Data memory read of the current address completes here
				loader_pkg::stop: begin
					state <= loader_pkg::send_hi;
				end
				// Hold while full
				loader_pkg::send_hi: begin
					if (!out_full) begin
						state <= loader_pkg::hi_gap;
					end
				end
				loader_pkg::hi_gap: begin
					state <= loader_pkg::send_lo;
				end
				loader_pkg::send_lo: begin
					if (!out_full) begin
						state <= loader_pkg::lo_gap;
					end
				end
				loader_pkg::lo_gap: begin
					state <= loader_pkg::next_send;
				end
				// Last entry sent, ready for a new program
				loader_pkg::next_send: begin
					if (last_word) begin
						state <= loader_pkg::wait_word;
					end else begin
						state <= loader_pkg::stop;
					end
				end
				default: begin
					state <= loader_pkg::wait_word;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/word_counter.sv */
`timescale 1ns/1ns
`default_nettype none

// One address register for both load and unload
module word_counter (
	input  wire                          CLOCK_50,
	input  wire                          rst_n,
	input  wire                          cnt_clear,
	input  wire                          cnt_step,
	output logic [loader_pkg::cnt_w-1:0] count
);

	// ==================================================
	// Address register
	// ==================================================

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			// Clear wins over step
			if (cnt_clear) begin
				count <= '0;
			end else if (cnt_step) begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/instr_mem.sv */
`timescale 1ns/1ns
`default_nettype none

// Program store, loader writes and coprocessor fetches
module instr_mem (
	input  wire                             CLOCK_50,
	input  wire                             imem_we,
	input  wire [loader_pkg::imem_aw-1:0]   wr_addr,
	input  wire [fifo_pkg::word_w-1:0]      wr_data,
	input  wire [loader_pkg::imem_aw-1:0]   rd_addr,
	output logic [fifo_pkg::word_w-1:0]     rd_data
);

	logic [fifo_pkg::word_w-1:0] mem [loader_pkg::imem_words];

	// ==================================================
	// Write and fetch ports
	// ==================================================

	always_ff @(posedge CLOCK_50) begin
		if (imem_we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Instruction shows up one cycle after the PC
	always_ff @(posedge CLOCK_50) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* logic/data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

// Coprocessor result store
module data_mem (
	input  wire                             CLOCK_50,
	input  wire                             we,
	input  wire [loader_pkg::dmem_aw-1:0]   wr_addr,
	input  wire [fifo_pkg::dword_w-1:0]     wr_data,
	input  wire [loader_pkg::dmem_aw-1:0]   rd_addr,
	output fifo_pkg::data_word_t            rd_word
);

	logic [fifo_pkg::dword_w-1:0] mem [loader_pkg::dmem_words];

	// ==================================================
	// Coprocessor write port
	// ==================================================

	// Only driven during the run phase
	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ==================================================
	// Unload read port
	// ==================================================

	// Reads every cycle from the shared counter
	// Word is valid one cycle after the address settles
	always_ff @(posedge CLOCK_50) begin
		rd_word.whole <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* logic/result_packer.sv */
`timescale 1ns/1ns
`default_nettype none

// Splits a data word into two outbound FIFO writes
module result_packer (
	input  wire                          CLOCK_50,
	input  wire                          rst_n,
	input  wire fifo_pkg::data_word_t    word,
	input  wire                          send_hi,
	input  wire                          send_lo,
	output logic [fifo_pkg::word_w-1:0]  out_data,
	output logic                         out_write
);

	// ==================================================
	// Write strobe
	// ==================================================

	// One cycle per requested half
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			out_write <= 1'b0;
		end else begin
			out_write <= send_hi || send_lo;
		end
	end

	// ==================================================
	// Write data
	// ==================================================

	// Upper half first, then lower
	always_ff @(posedge CLOCK_50) begin
		if (send_hi) begin
			out_data <= word.halves.hi;
		end else if (send_lo) begin
			out_data <= word.halves.lo;
		end
	end

endmodule

`default_nettype wire

/* logic/coproc_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module coproc_loader (
	input  wire                            CLOCK_50,
	input  wire                            rst_n,
	// Inbound FIFO
	input  wire                            in_empty,
	output wire                            in_read,
	input  wire [fifo_pkg::word_w-1:0]     in_data,
	// Outbound FIFO
	input  wire                            out_full,
	output wire                            out_write,
	output wire [fifo_pkg::word_w-1:0]     out_data,
	// Coprocessor control
	output wire                            cpu_start,
	output wire                            cpu_run,
	input  wire                            cpu_done,
	// Coprocessor fetch port
	input  wire [loader_pkg::imem_aw-1:0]  cpu_pc,
	output wire [fifo_pkg::word_w-1:0]     cpu_instr,
	// Coprocessor data memory write port
	input  wire                            cpu_dmem_we,
	input  wire [loader_pkg::dmem_aw-1:0]  cpu_dmem_addr,
	input  wire [fifo_pkg::dword_w-1:0]    cpu_dmem_wdata
);

	wire [loader_pkg::cnt_w-1:0] count;
	wire cnt_clear;
	wire cnt_step;
	wire imem_we;
	wire send_hi;
	wire send_lo;
	fifo_pkg::data_word_t dmem_word;

	// ==================================================
	// Control
	// ==================================================

	load_sequencer i_load_sequencer (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.in_empty  (in_empty),
		.out_full  (out_full),
		.cpu_done  (cpu_done),
		.in_data   (in_data),
		.count     (count),
		.in_read   (in_read),
		.imem_we   (imem_we),
		.cnt_clear (cnt_clear),
		.cnt_step  (cnt_step),
		.cpu_start (cpu_start),
		.cpu_run   (cpu_run),
		.send_hi   (send_hi),
		.send_lo   (send_lo)
	);

	// Load address and unload address
	word_counter i_word_counter (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.cnt_clear (cnt_clear),
		.cnt_step  (cnt_step),
		.count     (count)
	);

	// ==================================================
	// Memories and output path
	// ==================================================

	// Loader writes straight from the FIFO word
	instr_mem i_instr_mem (
		.CLOCK_50 (CLOCK_50),
		.imem_we  (imem_we),
		.wr_addr  (count[loader_pkg::imem_aw-1:0]),
		.wr_data  (in_data),
		.rd_addr  (cpu_pc),
		.rd_data  (cpu_instr)
	);

	// Low counter bits index the smaller data memory
	data_mem i_data_mem (
		.CLOCK_50 (CLOCK_50),
		.we       (cpu_dmem_we),
		.wr_addr  (cpu_dmem_addr),
		.wr_data  (cpu_dmem_wdata),
		.rd_addr  (count[loader_pkg::dmem_aw-1:0]),
		.rd_word  (dmem_word)
	);

	result_packer i_result_packer (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.word      (dmem_word),
		.send_hi   (send_hi),
		.send_lo   (send_lo),
		.out_data  (out_data),
		.out_write (out_write)
	);

endmodule

`default_nettype wire

/* bench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ==================================================
// Error report and compare
// ==================================================

task automatic fail_run(input string why);
	$display("%s", why);
	$display("TEST FAIL");
	$fatal(1, "stopped at first error");
endtask

task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
	if (got !== want) begin
		fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
			$time, name, got, want));
	end
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	return x;
endfunction

// ==================================================
// Waits
// ==================================================

task automatic wait_cpu_start(input int limit);
	int cycles;
	cycles = 0;
	do begin
		@(posedge CLOCK_50);
		cycles++;
		if (cycles > limit) begin
			fail_run("timeout waiting for cpu_start after the program was queued");
		end
	end while (!cpu_start);
endtask

// Checked between edges once the monitor has pushed
task automatic wait_writes(input int count, input int limit);
	int cycles;
	cycles = 0;
	while (out_words.size() < count) begin
		@(negedge CLOCK_50);
		cycles++;
		if (cycles > limit) begin
			fail_run("timeout waiting for the outbound FIFO writes");
		end
	end
endtask

// ==================================================
// Directed tests
// ==================================================

task automatic test_reset_values();
	compare("in_read", in_read, 1'b0);
	compare("out_write", out_write, 1'b0);
	compare("cpu_start", cpu_start, 1'b0);
	compare("cpu_run", cpu_run, 1'b0);
endtask

// Load, run and unload one program of len words
task automatic test_program(input int len, input logic stress);
	logic [fifo_pkg::word_w-1:0] want;
	logic [fifo_pkg::word_w-1:0] want_lo;
	prog.delete();
	// Top bit clear keeps the terminator out of the body
	for (int i = 0; i < len; i++) begin
		data_rng = xorshift32(data_rng);
		prog.push_back(data_rng & 32'h7fffffff);
	end
	@(negedge CLOCK_50);
	in_stall = stress;
	out_stall = stress;
	out_words.delete();
	foreach (prog[i]) begin
		host_words.push_back(prog[i]);
	end
	host_words.push_back(fifo_pkg::prog_end);
	wait_cpu_start(100 * len + 100);
	compare("cpu_run", cpu_run, 1'b0);
	@(posedge CLOCK_50);
	compare("cpu_start", cpu_start, 1'b0);
	compare("cpu_run", cpu_run, 1'b1);
	fetch_program(len);
	write_results(len);
	finish_run();
	wait_writes(2 * loader_pkg::dmem_words, 4000);
	// Address order with the upper half first
	for (int i = 0; i < loader_pkg::dmem_words; i++) begin
		want = prog[i % len];
		// Lower half is the inverse of the 32-bit instruction only
		want_lo = ~want;
		compare("out_data upper half", out_words[2 * i], want);
		compare("out_data lower half", out_words[2 * i + 1], want_lo);
	end
	// Nothing extra after the last data word
	repeat (20) @(negedge CLOCK_50);
	compare("outbound write count", out_words.size(), 2 * loader_pkg::dmem_words);
	in_stall = 1'b0;
	out_stall = 1'b0;
endtask

`endif

/* bench/tb_coproc_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_coproc_loader;

	localparam logic [31:0] seed = 32'h0f45399c;

	// ==================================================
	// Clock, reset and DUT ports
	// ==================================================

	logic CLOCK_50 = 1'b0;
	logic rst_n;
	logic in_empty = 1'b1;
	logic in_read;
	logic [fifo_pkg::word_w-1:0] in_data = '0;
	logic out_full = 1'b0;
	logic out_write;
	logic [fifo_pkg::word_w-1:0] out_data;
	logic cpu_start;
	logic cpu_run;
	logic cpu_done;
	logic [loader_pkg::imem_aw-1:0] cpu_pc;
	logic [fifo_pkg::word_w-1:0] cpu_instr;
	logic cpu_dmem_we;
	logic [loader_pkg::dmem_aw-1:0] cpu_dmem_addr;
	logic [fifo_pkg::dword_w-1:0] cpu_dmem_wdata;

	// Host side of both FIFOs
	logic [fifo_pkg::word_w-1:0] host_words[$];
	logic [fifo_pkg::word_w-1:0] out_words[$];

	// Program under test and what the coprocessor fetched
	logic [fifo_pkg::word_w-1:0] prog[$];
	logic [fifo_pkg::word_w-1:0] fetched[$];

	// Random stall enables, one per FIFO
	logic in_stall;
	logic out_stall;
	logic [31:0] data_rng;
	logic [31:0] stall_rng = ~seed;

	// FIFO levels as the DUT saw them one cycle back
	logic empty_prev = 1'b1;
	logic full_prev = 1'b0;

	`include "tb_tasks.svh"

	always #20 CLOCK_50 = ~CLOCK_50;

	coproc_loader i_coproc_loader (
		.CLOCK_50       (CLOCK_50),
		.rst_n          (rst_n),
		.in_empty       (in_empty),
		.in_read        (in_read),
		.in_data        (in_data),
		.out_full       (out_full),
		.out_write      (out_write),
		.out_data       (out_data),
		.cpu_start      (cpu_start),
		.cpu_run        (cpu_run),
		.cpu_done       (cpu_done),
		.cpu_pc         (cpu_pc),
		.cpu_instr      (cpu_instr),
		.cpu_dmem_we    (cpu_dmem_we),
		.cpu_dmem_addr  (cpu_dmem_addr),
		.cpu_dmem_wdata (cpu_dmem_wdata)
	);

	// ==================================================
	// FIFO models
	// ==================================================

	// Pop on read, word held until the next read
	// One xorshift step per cycle feeds both stall patterns
	always @(posedge CLOCK_50) begin
		stall_rng = xorshift32(stall_rng);
		if (in_read && host_words.size() != 0) begin
			in_data <= host_words.pop_front();
		end
		in_empty <= (host_words.size() == 0) || (in_stall && stall_rng[0]);
		out_full <= out_stall && stall_rng[1];
	end

	// Capture outbound writes, strobes must follow a free level
	always @(posedge CLOCK_50) begin
		if (in_read) begin
			compare("in_empty before in_read", empty_prev, 1'b0);
		end
		if (out_write) begin
			compare("out_full before out_write", full_prev, 1'b0);
			out_words.push_back(out_data);
		end
		empty_prev <= in_empty;
		full_prev <= out_full;
	end

	// ==================================================
	// Coprocessor model
	// ==================================================

	// Fetch each loaded address, instruction returns one cycle late
	task automatic fetch_program(input int len);
		fetched.delete();
		for (int i = 0; i < len; i++) begin
			@(posedge CLOCK_50);
			cpu_pc <= loader_pkg::imem_aw'(i);
			@(posedge CLOCK_50);
			@(posedge CLOCK_50);
			compare("cpu_run", cpu_run, 1'b1);
			compare("cpu_instr", cpu_instr, prog[i]);
			fetched.push_back(cpu_instr);
		end
	endtask

	// Result i is instruction i mod len and its inverse
	task automatic write_results(input int len);
		for (int i = 0; i < loader_pkg::dmem_words; i++) begin
			@(posedge CLOCK_50);
			compare("cpu_run", cpu_run, 1'b1);
			cpu_dmem_we <= 1'b1;
			cpu_dmem_addr <= loader_pkg::dmem_aw'(i);
			cpu_dmem_wdata <= {fetched[i % len], ~fetched[i % len]};
		end
		@(posedge CLOCK_50);
		cpu_dmem_we <= 1'b0;
	endtask

	// Done seen in one cycle, run low the cycle after
	task automatic finish_run();
		@(posedge CLOCK_50);
		cpu_done <= 1'b1;
		@(posedge CLOCK_50);
		compare("cpu_run", cpu_run, 1'b1);
		@(posedge CLOCK_50);
		compare("cpu_run", cpu_run, 1'b0);
		cpu_done <= 1'b0;
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		data_rng = seed;
		in_stall = 1'b0;
		out_stall = 1'b0;
		rst_n = 1'b0;
		cpu_done = 1'b0;
		cpu_pc = '0;
		cpu_dmem_we = 1'b0;
		cpu_dmem_addr = '0;
		cpu_dmem_wdata = '0;
		repeat (8) @(posedge CLOCK_50);
		rst_n <= 1'b1;
		@(posedge CLOCK_50);
		test_reset_values();
		// Quiet FIFOs first, then random stalls and other lengths
		test_program(8, 1'b0);
		test_program(5, 1'b1);
		test_program(13, 1'b1);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+bench
logic/fifo_pkg.sv
logic/loader_pkg.sv
logic/load_sequencer.sv
logic/word_counter.sv
logic/instr_mem.sv
logic/data_mem.sv
logic/result_packer.sv
logic/coproc_loader.sv
bench/tb_coproc_loader.sv

/* run.sh */
#!/bin/sh
# Build and run the coproc_loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_coproc_loader -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_coproc_loader)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
	exit 0
else
	exit 1
fi
